// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       := adbg_tb
FILELIST  := adbg_top.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: adbg_top.f
+incdir+src
src/adbg_pkg.sv
src/adbg_dr_if.sv
src/adbg_bus_module.sv
src/adbg_cpu_module.sv
src/adbg_top.sv
test/adbg_tb.sv

// File: src/adbg_bus_module.sv
`include "adbg_defs.svh"

`timescale 1ns/1ps
`default_nettype none

module adbg_bus_module
  import adbg_pkg::*;
(
  input  wire        tck_i,
  input  wire        rst_i,
  adbg_dr_if.mod     dr,
  input  wire        select_i,
  output logic       tdo_o,
  output logic       inhibit_o,
  // Single-word bus master
  output logic       bus_stb_o,
  output logic       bus_we_o,
  output adbg_word_t bus_adr_o,
  output adbg_word_t bus_wdata_o,
  input  wire        bus_ack_i,
  input  adbg_word_t bus_rdata_i
);

  ////////////////////
  // Command decode
  ////////////////////

  adbg_op_t   op;
  adbg_word_t arg;
  logic       cmd_valid;
  logic       access_start;

  // Registers
  bus_state_e state_q;
  logic       stb_q;
  logic       we_q;
  logic       rdy_q;
  adbg_word_t adr_q;
  adbg_word_t wdata_q;
  adbg_word_t rdata_q;
  logic [32:0] out_q;

  assign op  = dr.dr[`ADBG_OP_MSB:`ADBG_OP_LSB];
  assign arg = dr.dr[`ADBG_ARG_MSB:`ADBG_ARG_LSB];

  // Module command, dropped while an access is outstanding
  assign cmd_valid = select_i && dr.update_dr && !dr.dr[`ADBG_SEL_BIT] &&
                     (state_q == BUS_IDLE);

  assign access_start = cmd_valid &&
                        ((op == `ADBG_OP_WRITE) || (op == `ADBG_OP_READ));

  ////////////////////
  // Access FSM
  ////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= BUS_IDLE;
      stb_q   <= 1'b0;
      we_q    <= 1'b0;
      rdy_q   <= 1'b0;
    end else begin
      // Strobe is a one-cycle pulse
      stb_q <= 1'b0;
      case (state_q)
        BUS_IDLE: begin
          if (access_start) begin
            state_q <= BUS_WAIT;
            stb_q   <= 1'b1;
            we_q    <= (op == `ADBG_OP_WRITE);
            rdy_q   <= 1'b0;
          end
        end
        BUS_WAIT: begin
          // Ack may come as early as the strobe cycle
          if (bus_ack_i) begin
            state_q <= BUS_IDLE;
            rdy_q   <= 1'b1;
          end
        end
        default: state_q <= BUS_IDLE;
      endcase
    end
  end

  // Address, write data, read data
  always_ff @(posedge tck_i) begin
    if (cmd_valid && (op == `ADBG_OP_SETADR)) begin
      adr_q <= arg;
    end else if (stb_q) begin
      // Next word once the current one is on the bus
      adr_q <= adr_q + 32'd4;
    end
    if (access_start && (op == `ADBG_OP_WRITE)) begin
      wdata_q <= arg;
    end
    if ((state_q == BUS_WAIT) && bus_ack_i && !we_q) begin
      rdata_q <= bus_rdata_i;
    end
  end

  ////////////////////
  // Output register
  ////////////////////

  // Ready flag in bit 0, read data above, shifted out LSB first
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      out_q <= '0;
    end else if (select_i && dr.capture_dr) begin
      out_q <= {rdata_q, rdy_q};
    end else if (select_i && dr.shift_dr) begin
      out_q <= {dr.tdi, out_q[32:1]};
    end
  end

  assign tdo_o       = out_q[0];
  assign inhibit_o   = (state_q == BUS_WAIT);
  assign bus_stb_o   = stb_q;
  assign bus_we_o    = we_q;
  assign bus_adr_o   = adr_q;
  assign bus_wdata_o = wdata_q;

  // Never a second strobe back to back
  a_stb_single: assert property (@(posedge tck_i) disable iff (rst_i)
    bus_stb_o |=> !bus_stb_o);

  // Slave answers only an outstanding access
  a_ack_in_wait: assert property (@(posedge tck_i) disable iff (rst_i)
    bus_ack_i |-> (state_q == BUS_WAIT));

endmodule

`default_nettype wire

// File: src/adbg_cpu_module.sv
`include "adbg_defs.svh"

`timescale 1ns/1ps
`default_nettype none

module adbg_cpu_module
  import adbg_pkg::*;
(
  input  wire    tck_i,
  input  wire    rst_i,
  adbg_dr_if.mod dr,
  input  wire    select_i,
  output logic   tdo_o,
  // Core control
  input  wire    cpu_bp_i,
  output logic   cpu_stall_o,
  output logic   cpu_rst_o
);

  adbg_op_t   op;
  adbg_word_t arg;
  logic       ctrl_wr;

  logic       stall_q;
  logic       rst_q;
  logic       bp_seen_q;
  logic [2:0] status_q;

  assign op  = dr.dr[`ADBG_OP_MSB:`ADBG_OP_LSB];
  assign arg = dr.dr[`ADBG_ARG_MSB:`ADBG_ARG_LSB];

  // CTRL command for this module
  assign ctrl_wr = select_i && dr.update_dr && !dr.dr[`ADBG_SEL_BIT] &&
                   (op == `ADBG_OP_CTRL);

  ////////////////////
  // Control bits
  ////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      stall_q   <= 1'b0;
      rst_q     <= 1'b0;
      bp_seen_q <= 1'b0;
    end else begin
      // Breakpoint beats a simultaneous CTRL write
      if (cpu_bp_i) begin
        stall_q   <= 1'b1;
        bp_seen_q <= 1'b1;
      end else if (ctrl_wr) begin
        stall_q   <= arg[0];
        bp_seen_q <= 1'b0;
      end
      if (ctrl_wr) begin
        rst_q <= arg[1];
      end
    end
  end

  // Status out, bp-seen in bit 0
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      status_q <= '0;
    end else if (select_i && dr.capture_dr) begin
      status_q <= {rst_q, stall_q, bp_seen_q};
    end else if (select_i && dr.shift_dr) begin
      status_q <= {dr.tdi, status_q[2:1]};
    end
  end

  assign tdo_o       = status_q[0];
  assign cpu_stall_o = stall_q;
  assign cpu_rst_o   = rst_q;

  // Core halts right after a breakpoint
  a_bp_stall: assert property (@(posedge tck_i) disable iff (rst_i)
    cpu_bp_i |=> cpu_stall_o);

endmodule

`default_nettype wire

// File: src/adbg_defs.svh
`ifndef ADBG_DEFS_SVH
`define ADBG_DEFS_SVH

// Input shift register length
`define ADBG_DR_LEN 53

// Top-level select flag
`define ADBG_SEL_BIT 52

// Module ID field of a select command
`define ADBG_ID_MSB 51
`define ADBG_ID_LSB 50

// Opcode and argument fields of a module command
`define ADBG_OP_MSB  51
`define ADBG_OP_LSB  48
`define ADBG_ARG_MSB 47
`define ADBG_ARG_LSB 16

// Debug module IDs, 2 and 3 reserved
`define ADBG_ID_BUS 2'd0
`define ADBG_ID_CPU 2'd1

// Module opcodes
`define ADBG_OP_SETADR 4'd1
`define ADBG_OP_WRITE  4'd2
`define ADBG_OP_READ   4'd3
`define ADBG_OP_CTRL   4'd4

`endif

// File: src/adbg_dr_if.sv
`timescale 1ns/1ps
`default_nettype none

// TAP strobes and shifted DR, fanned out from top to the debug modules
interface adbg_dr_if
  import adbg_pkg::*;
();

  // Serial input, shared by all module output registers
  logic     tdi;

  // TAP state strobes
  logic     shift_dr;
  logic     capture_dr;
  logic     update_dr;

  // Contents of the top input shift register
  adbg_dr_t dr;

  // Top side drives everything
  modport drv (output tdi, shift_dr, capture_dr, update_dr, dr);

  // Debug modules only listen
  modport mod (input tdi, shift_dr, capture_dr, update_dr, dr);

endinterface

`default_nettype wire

// File: src/adbg_pkg.sv
`default_nettype none

`include "adbg_defs.svh"

package adbg_pkg;

  ////////////////////
  // Vector types
  ////////////////////

  // Full shifted data register
  typedef logic [`ADBG_DR_LEN-1:0] adbg_dr_t;

  // Bus address or data word
  typedef logic [`ADBG_ARG_MSB-`ADBG_ARG_LSB:0] adbg_word_t;

  // Module ID and opcode fields
  typedef logic [`ADBG_ID_MSB-`ADBG_ID_LSB:0] adbg_id_t;
  typedef logic [`ADBG_OP_MSB-`ADBG_OP_LSB:0] adbg_op_t;

  ////////////////////
  // FSM states
  ////////////////////

  // Bus module access FSM
  typedef enum logic {
    BUS_IDLE,
    BUS_WAIT  // Strobe sent, waiting for ack
  } bus_state_e;

endpackage

`default_nettype wire

// File: src/adbg_top.sv
`include "adbg_defs.svh"

`timescale 1ns/1ps
`default_nettype none

module adbg_top
  import adbg_pkg::*;
(
  input  wire        tck_i,
  input  wire        rst_i,
  input  wire        tdi_i,
  output logic       tdo_o,
  // TAP state strobes
  input  wire        shift_dr_i,
  input  wire        capture_dr_i,
  input  wire        update_dr_i,
  input  wire        debug_select_i,
  // Bus master
  output logic       bus_stb_o,
  output logic       bus_we_o,
  output adbg_word_t bus_adr_o,
  output adbg_word_t bus_wdata_o,
  input  wire        bus_ack_i,
  input  adbg_word_t bus_rdata_i,
  // Core control
  input  wire        cpu_bp_i,
  output logic       cpu_stall_o,
  output logic       cpu_rst_o
);

  adbg_dr_t input_shift_reg;
  adbg_id_t module_id_reg;
  logic     bus_sel;
  logic     cpu_sel;
  logic     bus_inhibit;
  logic     tdo_bus;
  logic     tdo_cpu;

  adbg_dr_if u_dr_if ();

  ////////////////////
  // Select logic
  ////////////////////

  // TDI enters at the MSB, first bit ends up in bit 0
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      input_shift_reg <= '0;
    end else if (debug_select_i && shift_dr_i) begin
      input_shift_reg <= {tdi_i, input_shift_reg[`ADBG_DR_LEN-1:1]};
    end
  end

  // New ID only when no bus access is pending
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      module_id_reg <= `ADBG_ID_BUS;
    end else if (debug_select_i && update_dr_i && input_shift_reg[`ADBG_SEL_BIT] &&
                 !bus_inhibit) begin
      module_id_reg <= input_shift_reg[`ADBG_ID_MSB:`ADBG_ID_LSB];
    end
  end

  assign bus_sel = debug_select_i && (module_id_reg == `ADBG_ID_BUS);
  assign cpu_sel = debug_select_i && (module_id_reg == `ADBG_ID_CPU);

  // Strobes and DR to the modules
  assign u_dr_if.tdi        = tdi_i;
  assign u_dr_if.shift_dr   = shift_dr_i;
  assign u_dr_if.capture_dr = capture_dr_i;
  assign u_dr_if.update_dr  = update_dr_i;
  assign u_dr_if.dr         = input_shift_reg;

  ////////////////////
  // Debug modules
  ////////////////////

  adbg_bus_module u_bus (
    .tck_i       (tck_i),
    .rst_i       (rst_i),
    .dr          (u_dr_if),
    .select_i    (bus_sel),
    .tdo_o       (tdo_bus),
    .inhibit_o   (bus_inhibit),
    .bus_stb_o   (bus_stb_o),
    .bus_we_o    (bus_we_o),
    .bus_adr_o   (bus_adr_o),
    .bus_wdata_o (bus_wdata_o),
    .bus_ack_i   (bus_ack_i),
    .bus_rdata_i (bus_rdata_i)
  );

  adbg_cpu_module u_cpu (
    .tck_i       (tck_i),
    .rst_i       (rst_i),
    .dr          (u_dr_if),
    .select_i    (cpu_sel),
    .tdo_o       (tdo_cpu),
    .cpu_bp_i    (cpu_bp_i),
    .cpu_stall_o (cpu_stall_o),
    .cpu_rst_o   (cpu_rst_o)
  );

  // TDO mux, reserved IDs read as zero
  always_comb begin
    case (module_id_reg)
      `ADBG_ID_BUS: tdo_o = tdo_bus;
      `ADBG_ID_CPU: tdo_o = tdo_cpu;
      default:      tdo_o = 1'b0;
    endcase
  end

  // Never two modules listening at once
  a_sel_onehot: assert property (@(posedge tck_i) disable iff (rst_i)
    $onehot0({bus_sel, cpu_sel}));

endmodule

`default_nettype wire

// File: test/adbg_tb.sv
`include "adbg_defs.svh"

`timescale 1ns/1ps
`default_nettype none

module adbg_tb
  import adbg_pkg::*;
();

  logic       tck_i;
  logic       rst_i;
  logic       tdi_i;
  logic       tdo_o;
  logic       shift_dr_i;
  logic       capture_dr_i;
  logic       update_dr_i;
  logic       debug_select_i;
  logic       bus_stb_o;
  logic       bus_we_o;
  adbg_word_t bus_adr_o;
  adbg_word_t bus_wdata_o;
  logic       bus_ack_i = 1'b0;
  adbg_word_t bus_rdata_i = '0;
  logic       cpu_bp_i;
  logic       cpu_stall_o;
  logic       cpu_rst_o;

  // Scoreboard and check enables
  adbg_word_t exp_adr;
  adbg_word_t exp_wdata;
  logic       exp_we;
  logic       exp_stall;
  logic       exp_rst;
  logic       chk_cpu;
  logic       chk_idle;
  logic       chk_tdo0;
  int         exp_stb;
  int         mism_cnt;
  int         other_cnt;

  // Bus slave state
  adbg_word_t mem [16];
  adbg_word_t data_seed;
  adbg_word_t dly_seed;
  logic [3:0] acc_idx;
  logic       hold_ack;
  logic       pending;
  int         ack_wait;
  int         stb_cnt;

  adbg_top u_adbg_top (.*);

  initial begin
    tck_i = 1'b0;
    forever #50 tck_i = ~tck_i;
  end

  function automatic adbg_word_t lcg_step(input adbg_word_t s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic void report_mismatch(input string name, input adbg_word_t got,
                                          input adbg_word_t exp);
    $display("mismatch %s: got %h expected %h", name, got, exp);
    mism_cnt++;
  endfunction

  ////////////////////
  // Bus slave model
  ////////////////////

  // Fill word depends on every index bit
  initial begin
    for (int i = 0; i < 16; i++) begin
      mem[i] = 32'h5a00_0000 | (32'(i) * 32'h0003_0101);
    end
  end

  // Ack 0 to 3 cycles after the strobe or much later on hold
  always @(negedge tck_i) begin
    bus_ack_i = 1'b0;
    if (bus_stb_o) begin
      stb_cnt++;
      acc_idx = bus_adr_o[5:2];
      if (bus_we_o) begin
        mem[acc_idx] = bus_wdata_o;
      end
      dly_seed = lcg_step(dly_seed);
      ack_wait = hold_ack ? 80 : int'(dly_seed[17:16]);
      pending  = 1'b1;
    end
    if (pending) begin
      if (ack_wait == 0) begin
        bus_ack_i   = 1'b1;
        bus_rdata_i = mem[acc_idx];
        pending     = 1'b0;
      end else begin
        ack_wait--;
      end
    end
  end

  ////////////////////
  // Output checks
  ////////////////////

  a_stb_adr: assert property (@(posedge tck_i) disable iff (rst_i)
    bus_stb_o |-> bus_adr_o == exp_adr)
    else report_mismatch("bus_adr_o", $sampled(bus_adr_o), exp_adr);

  a_stb_we: assert property (@(posedge tck_i) disable iff (rst_i)
    bus_stb_o |-> bus_we_o == exp_we)
    else report_mismatch("bus_we_o", 32'($sampled(bus_we_o)), 32'(exp_we));

  a_stb_wdata: assert property (@(posedge tck_i) disable iff (rst_i)
    (bus_stb_o && exp_we) |-> bus_wdata_o == exp_wdata)
    else report_mismatch("bus_wdata_o", $sampled(bus_wdata_o), exp_wdata);

  a_cpu_stall: assert property (@(posedge tck_i) disable iff (rst_i)
    chk_cpu |-> cpu_stall_o == exp_stall)
    else report_mismatch("cpu_stall_o", 32'($sampled(cpu_stall_o)), 32'(exp_stall));

  a_cpu_rst: assert property (@(posedge tck_i) disable iff (rst_i)
    chk_cpu |-> cpu_rst_o == exp_rst)
    else report_mismatch("cpu_rst_o", 32'($sampled(cpu_rst_o)), 32'(exp_rst));

  // Reset state and reserved IDs keep TDO low
  a_tdo_low: assert property (@(posedge tck_i) disable iff (rst_i)
    chk_tdo0 |-> !tdo_o)
    else report_mismatch("tdo_o", 32'($sampled(tdo_o)), 32'd0);

  a_stb_idle: assert property (@(posedge tck_i) disable iff (rst_i)
    chk_idle |-> !bus_stb_o)
    else report_mismatch("bus_stb_o", 32'($sampled(bus_stb_o)), 32'd0);

  ////////////////////
  // TAP strobe tasks
  ////////////////////

  // LSB first in and out with TDO sampled at the falling edge
  task automatic shift_word(input adbg_dr_t w, input int len, output adbg_dr_t out);
    out = '0;
    for (int i = 0; i < len; i++) begin
      @(negedge tck_i);
      out[i]     = tdo_o;
      tdi_i      = w[i];
      shift_dr_i = 1'b1;
    end
    @(negedge tck_i);
    shift_dr_i = 1'b0;
  endtask

  task automatic capture();
    @(negedge tck_i);
    capture_dr_i = 1'b1;
    @(negedge tck_i);
    capture_dr_i = 1'b0;
  endtask

  task automatic update();
    @(negedge tck_i);
    update_dr_i = 1'b1;
    @(negedge tck_i);
    update_dr_i = 1'b0;
  endtask

  task automatic send_cmd(input adbg_op_t op, input adbg_word_t arg);
    adbg_dr_t w;
    adbg_dr_t junk;
    w = '0;
    w[`ADBG_OP_MSB:`ADBG_OP_LSB]   = op;
    w[`ADBG_ARG_MSB:`ADBG_ARG_LSB] = arg;
    shift_word(w, `ADBG_DR_LEN, junk);
    update();
  endtask

  task automatic select_module(input adbg_id_t id);
    adbg_dr_t w;
    adbg_dr_t junk;
    w = '0;
    w[`ADBG_SEL_BIT]               = 1'b1;
    w[`ADBG_ID_MSB:`ADBG_ID_LSB]   = id;
    shift_word(w, `ADBG_DR_LEN, junk);
    update();
  endtask

  // Ack sampled at the rising edge where it is stable
  task automatic wait_ack(input int limit);
    int n;
    n = 0;
    @(posedge tck_i);
    while (!bus_ack_i && n < limit) begin
      @(posedge tck_i);
      n++;
    end
    if (!bus_ack_i) begin
      $display("timeout: no bus ack within %0d cycles", limit);
      other_cnt++;
    end
    @(negedge tck_i);
  endtask

  // One-cycle window for the CPU output assertions
  task automatic expect_cpu(input logic stall, input logic rst);
    exp_stall = stall;
    exp_rst   = rst;
    chk_cpu   = 1'b1;
    @(negedge tck_i);
    chk_cpu   = 1'b0;
  endtask

  task automatic write_word(input adbg_word_t adr, input adbg_word_t data);
    exp_adr   = adr;
    exp_we    = 1'b1;
    exp_wdata = data;
    exp_stb++;
    send_cmd(`ADBG_OP_WRITE, data);
    wait_ack(20);
  endtask

  // Read then capture and shift out ready flag and data
  task automatic read_check(input adbg_word_t adr);
    adbg_dr_t out;
    exp_adr = adr;
    exp_we  = 1'b0;
    exp_stb++;
    send_cmd(`ADBG_OP_READ, '0);
    wait_ack(20);
    capture();
    shift_word('0, 33, out);
    assert (out[0] == 1'b1)
      else report_mismatch("ready flag", 32'(out[0]), 32'd1);
    assert (out[32:1] == mem[adr[5:2]])
      else report_mismatch("read data", out[32:1], mem[adr[5:2]]);
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    adbg_dr_t out;
    adbg_dr_t w;
    rst_i          = 1'b1;
    tdi_i          = 1'b0;
    shift_dr_i     = 1'b0;
    capture_dr_i   = 1'b0;
    update_dr_i    = 1'b0;
    debug_select_i = 1'b1;
    cpu_bp_i       = 1'b0;
    {chk_cpu, chk_idle, chk_tdo0, hold_ack, pending} = '0;
    {exp_adr, exp_wdata, exp_we, exp_stall, exp_rst} = '0;
    {exp_stb, mism_cnt, other_cnt, stb_cnt, ack_wait} = '0;
    data_seed = 32'd32;
    dly_seed  = 32'd32;
    repeat (3) @(posedge tck_i);
    @(negedge tck_i);
    rst_i = 1'b0;

    // Reset state
    chk_idle = 1'b1;
    chk_tdo0 = 1'b1;
    expect_cpu(1'b0, 1'b0);
    chk_idle = 1'b0;
    chk_tdo0 = 1'b0;

    // Three writes from a base address
    send_cmd(`ADBG_OP_SETADR, 32'h10);
    for (int k = 0; k < 3; k++) begin
      data_seed = lcg_step(data_seed);
      write_word(32'h10 + 32'(4 * k), data_seed);
    end

    // Read back two consecutive words
    send_cmd(`ADBG_OP_SETADR, 32'h10);
    read_check(32'h10);
    read_check(32'h14);

    // CPU stall and reset control
    select_module(`ADBG_ID_CPU);
    send_cmd(`ADBG_OP_CTRL, 32'h3);
    expect_cpu(1'b1, 1'b1);
    send_cmd(`ADBG_OP_CTRL, 32'h0);
    expect_cpu(1'b0, 1'b0);
    @(negedge tck_i);
    cpu_bp_i = 1'b1;
    @(negedge tck_i);
    cpu_bp_i = 1'b0;
    expect_cpu(1'b1, 1'b0);
    // Status order is bp-seen, stall, reset
    capture();
    shift_word('0, 3, out);
    assert (out[2:0] == 3'b011)
      else report_mismatch("cpu status", 32'(out[2:0]), 32'h3);

    // Select command during a held read must be dropped
    select_module(`ADBG_ID_BUS);
    send_cmd(`ADBG_OP_SETADR, 32'h30);
    hold_ack = 1'b1;
    exp_adr  = 32'h30;
    exp_we   = 1'b0;
    exp_stb++;
    send_cmd(`ADBG_OP_READ, '0);
    select_module(`ADBG_ID_CPU);
    wait_ack(120);
    hold_ack = 1'b0;
    read_check(32'h34);

    // Reserved ID reads as zero
    // Ones in the unused select bits leave the bus module TDO high
    w = '1;
    w[`ADBG_ID_MSB:`ADBG_ID_LSB] = 2'd2;
    shift_word(w, `ADBG_DR_LEN, out);
    update();
    chk_tdo0 = 1'b1;
    capture();
    shift_word('0, 33, out);
    chk_tdo0 = 1'b0;

    assert (stb_cnt == exp_stb)
      else report_mismatch("strobe count", 32'(stb_cnt), 32'(exp_stb));

    $display("errors: %0d mismatch, %0d other", mism_cnt, other_cnt);
    if (mism_cnt == 0 && other_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
